// ==== hw/usb_ctl_pkg.sv ====
package usb_ctl_pkg;

  // Standard bRequest codes handled by pipe 0
  localparam logic [7:0] REQ_GET_DESCRIPTOR    = 8'd6;
  localparam logic [7:0] REQ_SET_ADDRESS       = 8'd5;
  localparam logic [7:0] REQ_SET_CONFIGURATION = 8'd9;

  // Descriptor types, found in wValue[15:8]
  localparam logic [7:0] DESC_TYPE_DEVICE = 8'd1;
  localparam logic [7:0] DESC_TYPE_CONFIG = 8'd2;
  localparam logic [7:0] DESC_TYPE_STRING = 8'd3;

  // Bit 0 is set for every kind that returns a descriptor
  typedef enum logic [2:0] {
    KIND_NONE        = 3'd0,
    KIND_GET_DEVICE  = 3'd1,
    KIND_SET_ADDRESS = 3'd2,
    KIND_GET_CONFIG  = 3'd3,
    KIND_SET_CONFIG  = 3'd4,
    KIND_GET_STRING  = 3'd5
  } req_kind_t;

  typedef logic [5:0] desc_addr_t;

  localparam logic [15:0] VENDOR_ID  = 16'hFACE;
  localparam logic [15:0] PRODUCT_ID = 16'h0BDE;

  localparam logic [7:0] PRODUCT_STRING_INDEX = 8'd2;

  localparam int DESC_SIZE = 54;

  localparam desc_addr_t DEVICE_START  = 6'd0;
  localparam desc_addr_t CONFIG_START  = 6'd18;
  localparam desc_addr_t STRING0_START = 6'd36;
  localparam desc_addr_t PRODUCT_START = 6'd40;

  localparam desc_addr_t DEVICE_LEN  = 6'd18;
  localparam desc_addr_t CONFIG_LEN  = 6'd18;
  localparam desc_addr_t STRING0_LEN = 6'd4;
  localparam desc_addr_t PRODUCT_LEN = 6'd14;

  // Multi-byte fields are little endian, as on the bus
  localparam logic [7:0] DESC_BYTES [DESC_SIZE] = '{
    // Device: bLength, type, bcdUSB 2.0, class FF, subclass, protocol, 64-byte EP0
    8'h12, 8'h01, 8'h00, 8'h02, 8'hFF, 8'h00, 8'h00, 8'h40,
    VENDOR_ID[7:0], VENDOR_ID[15:8], PRODUCT_ID[7:0], PRODUCT_ID[15:8],
    // bcdDevice, iManufacturer, iProduct, iSerialNumber, one configuration
    8'h00, 8'h00, 8'h00, 8'h02, 8'h00, 8'h01,
    // Configuration: wTotalLength 18, one interface, value 1, self powered, 100 mA
    8'h09, 8'h02, 8'h12, 8'h00, 8'h01, 8'h01, 8'h00, 8'hC0, 8'h32,
    // Interface 0 with no endpoints
    8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00, 8'h00,
    // String zero, language 0x0409
    8'h04, 8'h03, 8'h09, 8'h04,
    // Product string "USBCTL" in UTF-16LE
    8'h0E, 8'h03, 8'h55, 8'h00, 8'h53, 8'h00, 8'h42, 8'h00,
    8'h43, 8'h00, 8'h54, 8'h00, 8'h4C, 8'h00
  };

endpackage

// ==== hw/setup_capture.sv ====
`timescale 1ns/1ns

module setup_capture (
  input  logic        clock,
  input  logic        reset,
  input  logic        setup_valid_i,
  input  logic [7:0]  setup_data_i,
  input  logic        status_done_i,
  output logic        select_o,
  output logic [7:0]  req_type_o,
  output logic [7:0]  req_code_o,
  output logic [15:0] req_value_o,
  output logic [15:0] req_length_o
);

  logic [2:0] byte_idx;
  logic       take_byte;

  // Packet is frozen once all eight bytes are in
  assign take_byte = setup_valid_i && !select_o;

  always_ff @(posedge clock) begin
    if (reset) begin
      byte_idx <= 3'd0;
      select_o <= 1'b0;
    end else begin
      if (take_byte) begin
        // Wraps back to zero after the eighth byte
        byte_idx <= byte_idx + 3'd1;
      end
      if (take_byte && byte_idx == 3'd7) begin
        select_o <= 1'b1;
      end else if (status_done_i) begin
        select_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (take_byte) begin
      case (byte_idx)
        3'd0: req_type_o <= setup_data_i;
        3'd1: req_code_o <= setup_data_i;
        3'd2: req_value_o[7:0] <= setup_data_i;
        3'd3: req_value_o[15:8] <= setup_data_i;
        // wIndex bytes are not used by this endpoint
        3'd6: req_length_o[7:0] <= setup_data_i;
        3'd7: req_length_o[15:8] <= setup_data_i;
        default: ;
      endcase
    end
  end

endmodule

// ==== hw/request_decoder.sv ====
`timescale 1ns/1ns

module request_decoder (
  input  logic [7:0]             req_type_i,
  input  logic [7:0]             req_code_i,
  input  logic [15:0]            req_value_i,
  output usb_ctl_pkg::req_kind_t req_kind_o,
  output logic                   req_index_o
);

  logic       std_device_req;
  logic [7:0] desc_type;
  logic [7:0] desc_index;
  logic       index_known;

  // Standard type and device recipient, direction bit ignored
  assign std_device_req = req_type_i[6:5] == 2'b00 && req_type_i[4:0] == 5'd0;

  assign desc_type  = req_value_i[15:8];
  assign desc_index = req_value_i[7:0];

  // Only string zero and the product string exist
  assign index_known = desc_index == 8'd0 ||
                       desc_index == usb_ctl_pkg::PRODUCT_STRING_INDEX;
  assign req_index_o = desc_index == usb_ctl_pkg::PRODUCT_STRING_INDEX;

  always_comb begin
    req_kind_o = usb_ctl_pkg::KIND_NONE;
    if (std_device_req) begin
      if (req_code_i == usb_ctl_pkg::REQ_GET_DESCRIPTOR) begin
        if (desc_type == usb_ctl_pkg::DESC_TYPE_DEVICE) begin
          req_kind_o = usb_ctl_pkg::KIND_GET_DEVICE;
        end else if (desc_type == usb_ctl_pkg::DESC_TYPE_CONFIG) begin
          req_kind_o = usb_ctl_pkg::KIND_GET_CONFIG;
        end else if (desc_type == usb_ctl_pkg::DESC_TYPE_STRING && index_known) begin
          req_kind_o = usb_ctl_pkg::KIND_GET_STRING;
        end
      end else if (req_code_i == usb_ctl_pkg::REQ_SET_ADDRESS) begin
        req_kind_o = usb_ctl_pkg::KIND_SET_ADDRESS;
      end else if (req_code_i == usb_ctl_pkg::REQ_SET_CONFIGURATION) begin
        req_kind_o = usb_ctl_pkg::KIND_SET_CONFIG;
      end
    end
  end

endmodule

// ==== hw/descriptor_rom.sv ====
`timescale 1ns/1ns

module descriptor_rom (
  input  usb_ctl_pkg::req_kind_t  req_kind_i,
  input  logic                    req_index_i,
  input  usb_ctl_pkg::desc_addr_t rd_addr_i,
  output usb_ctl_pkg::desc_addr_t desc_start_o,
  output usb_ctl_pkg::desc_addr_t desc_len_o,
  output logic [7:0]              rom_data_o
);

  // Addresses past the table read as zero
  always_comb begin
    if (int'(rd_addr_i) < usb_ctl_pkg::DESC_SIZE) begin
      rom_data_o = usb_ctl_pkg::DESC_BYTES[rd_addr_i];
    end else begin
      rom_data_o = 8'h00;
    end
  end

  always_comb begin
    case (req_kind_i)
      usb_ctl_pkg::KIND_GET_CONFIG: begin
        desc_start_o = usb_ctl_pkg::CONFIG_START;
        desc_len_o   = usb_ctl_pkg::CONFIG_LEN;
      end
      usb_ctl_pkg::KIND_GET_STRING: begin
        if (req_index_i) begin
          desc_start_o = usb_ctl_pkg::PRODUCT_START;
          desc_len_o   = usb_ctl_pkg::PRODUCT_LEN;
        end else begin
          desc_start_o = usb_ctl_pkg::STRING0_START;
          desc_len_o   = usb_ctl_pkg::STRING0_LEN;
        end
      end
      // Device descriptor also covers the non-get kinds, never streamed
      default: begin
        desc_start_o = usb_ctl_pkg::DEVICE_START;
        desc_len_o   = usb_ctl_pkg::DEVICE_LEN;
      end
    endcase
  end

endmodule

// ==== hw/desc_read_counter.sv ====
`timescale 1ns/1ns

module desc_read_counter (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    load_i,
  input  usb_ctl_pkg::desc_addr_t start_i,
  input  usb_ctl_pkg::desc_addr_t desc_len_i,
  input  logic [15:0]             req_length_i,
  input  logic                    m_tready_i,
  output usb_ctl_pkg::desc_addr_t rd_addr_o,
  output logic                    m_tvalid_o,
  output logic                    m_tlast_o,
  output logic                    stream_done_o
);

  // Bytes still to send, including the one on the bus
  usb_ctl_pkg::desc_addr_t remaining;
  usb_ctl_pkg::desc_addr_t load_count;
  logic                    handshake;

  // Host may ask for fewer bytes than the descriptor holds
  always_comb begin
    if (16'(desc_len_i) <= req_length_i) begin
      load_count = desc_len_i;
    end else begin
      load_count = req_length_i[5:0];
    end
  end

  assign handshake = m_tvalid_o && m_tready_i;
  assign m_tlast_o = m_tvalid_o && remaining == 6'd1;

  // An empty transfer is finished as soon as it is loaded
  assign stream_done_o = (handshake && remaining == 6'd1) || (load_i && load_count == 6'd0);

  always_ff @(posedge clock) begin
    if (reset) begin
      m_tvalid_o <= 1'b0;
    end else if (load_i) begin
      m_tvalid_o <= load_count != 6'd0;
    end else if (handshake && remaining == 6'd1) begin
      m_tvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (load_i) begin
      rd_addr_o <= start_i;
      remaining <= load_count;
    end else if (handshake) begin
      rd_addr_o <= rd_addr_o + 6'd1;
      remaining <= remaining - 6'd1;
    end
  end

endmodule

// ==== hw/ctl_pipe0_fsm.sv ====
`timescale 1ns/1ns

module ctl_pipe0_fsm (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   select_i,
  input  usb_ctl_pkg::req_kind_t req_kind_i,
  input  logic [15:0]            req_value_i,
  input  logic                   stream_done_i,
  output logic                   load_stream_o,
  output logic                   accept_o,
  output logic                   error_o,
  output logic                   configured_o,
  output logic [6:0]             usb_addr_o,
  output logic [7:0]             usb_conf_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_GET_DESC,
    ST_SET_ADDR,
    ST_SET_CONF,
    ST_REJECT
  } state_t;

  state_t state;
  // Set while the counter still owes bytes for this transfer
  logic   stream_busy;

  always_ff @(posedge clock) begin
    if (reset) begin
      state         <= ST_IDLE;
      stream_busy   <= 1'b0;
      load_stream_o <= 1'b0;
      accept_o      <= 1'b0;
      error_o       <= 1'b0;
      configured_o  <= 1'b0;
      usb_addr_o    <= 7'd0;
      usb_conf_o    <= 8'd0;
    end else begin
      load_stream_o <= 1'b0;
      if (stream_done_i) begin
        stream_busy <= 1'b0;
      end
      if (!select_i) begin
        accept_o <= 1'b0;
        error_o  <= 1'b0;
      end
      case (state)
        ST_IDLE: begin
          if (select_i) begin
            accept_o <= req_kind_i != usb_ctl_pkg::KIND_NONE;
            error_o  <= req_kind_i == usb_ctl_pkg::KIND_NONE;
            case (req_kind_i)
              usb_ctl_pkg::KIND_GET_DEVICE,
              usb_ctl_pkg::KIND_GET_CONFIG,
              usb_ctl_pkg::KIND_GET_STRING: begin
                state         <= ST_GET_DESC;
                load_stream_o <= 1'b1;
                stream_busy   <= 1'b1;
              end
              usb_ctl_pkg::KIND_SET_ADDRESS: state <= ST_SET_ADDR;
              usb_ctl_pkg::KIND_SET_CONFIG:  state <= ST_SET_CONF;
              default:                       state <= ST_REJECT;
            endcase
          end
        end
        // Wait for the status stage and for the last byte to leave
        ST_GET_DESC: begin
          if (!select_i && !stream_busy) begin
            state <= ST_IDLE;
          end
        end
        // New address only takes effect after the status stage
        ST_SET_ADDR: begin
          if (!select_i) begin
            usb_addr_o <= req_value_i[6:0];
            state      <= ST_IDLE;
          end
        end
        ST_SET_CONF: begin
          if (!select_i) begin
            usb_conf_o   <= req_value_i[7:0];
            configured_o <= req_value_i[7:0] != 8'd0;
            state        <= ST_IDLE;
          end
        end
        default: begin
          if (!select_i) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== hw/ctl_pipe0_top.sv ====
`timescale 1ns/1ns

module ctl_pipe0_top (
  input  logic       clock,
  input  logic       reset,
  input  logic       setup_valid_i,
  input  logic [7:0] setup_data_i,
  input  logic       status_done_i,
  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic       m_tlast_o,
  output logic [7:0] m_tdata_o,
  output logic       accept_o,
  output logic       error_o,
  output logic       configured_o,
  output logic [6:0] usb_addr_o,
  output logic [7:0] usb_conf_o
);

  logic                    select;
  logic [7:0]              req_type;
  logic [7:0]              req_code;
  logic [15:0]             req_value;
  logic [15:0]             req_length;
  usb_ctl_pkg::req_kind_t  req_kind;
  logic                    req_index;
  usb_ctl_pkg::desc_addr_t desc_start;
  usb_ctl_pkg::desc_addr_t desc_len;
  usb_ctl_pkg::desc_addr_t rd_addr;
  logic                    load_stream;
  logic                    stream_done;

  setup_capture i_setup_capture (
    .clock         (clock),
    .reset         (reset),
    .setup_valid_i (setup_valid_i),
    .setup_data_i  (setup_data_i),
    .status_done_i (status_done_i),
    .select_o      (select),
    .req_type_o    (req_type),
    .req_code_o    (req_code),
    .req_value_o   (req_value),
    .req_length_o  (req_length)
  );

  request_decoder i_request_decoder (
    .req_type_i  (req_type),
    .req_code_i  (req_code),
    .req_value_i (req_value),
    .req_kind_o  (req_kind),
    .req_index_o (req_index)
  );

  // ROM data goes straight out as the stream payload
  descriptor_rom i_descriptor_rom (
    .req_kind_i   (req_kind),
    .req_index_i  (req_index),
    .rd_addr_i    (rd_addr),
    .desc_start_o (desc_start),
    .desc_len_o   (desc_len),
    .rom_data_o   (m_tdata_o)
  );

  desc_read_counter i_desc_read_counter (
    .clock         (clock),
    .reset         (reset),
    .load_i        (load_stream),
    .start_i       (desc_start),
    .desc_len_i    (desc_len),
    .req_length_i  (req_length),
    .m_tready_i    (m_tready_i),
    .rd_addr_o     (rd_addr),
    .m_tvalid_o    (m_tvalid_o),
    .m_tlast_o     (m_tlast_o),
    .stream_done_o (stream_done)
  );

  ctl_pipe0_fsm i_ctl_pipe0_fsm (
    .clock         (clock),
    .reset         (reset),
    .select_i      (select),
    .req_kind_i    (req_kind),
    .req_value_i   (req_value),
    .stream_done_i (stream_done),
    .load_stream_o (load_stream),
    .accept_o      (accept_o),
    .error_o       (error_o),
    .configured_o  (configured_o),
    .usb_addr_o    (usb_addr_o),
    .usb_conf_o    (usb_conf_o)
  );

endmodule

// ==== verification/tb_ctl_pipe0.sv ====
`timescale 1ns/1ns

module tb_ctl_pipe0;

  logic       clock;
  logic       reset;
  logic       setup_valid_i;
  logic [7:0] setup_data_i;
  logic       status_done_i;
  logic       m_tvalid_o;
  logic       m_tready_i;
  logic       m_tlast_o;
  logic [7:0] m_tdata_o;
  logic       accept_o;
  logic       error_o;
  logic       configured_o;
  logic [6:0] usb_addr_o;
  logic [7:0] usb_conf_o;

  int          mismatches;
  int          failures;
  int          transfers;
  logic [31:0] rng_state;
  logic [7:0]  expect_q [$];
  logic [7:0]  expect_data;
  logic        expect_last;
  // High while a get request is allowed to stream
  logic        stream_open;

  ctl_pipe0_top i_dut (
    .clock         (clock),
    .reset         (reset),
    .setup_valid_i (setup_valid_i),
    .setup_data_i  (setup_data_i),
    .status_done_i (status_done_i),
    .m_tvalid_o    (m_tvalid_o),
    .m_tready_i    (m_tready_i),
    .m_tlast_o     (m_tlast_o),
    .m_tdata_o     (m_tdata_o),
    .accept_o      (accept_o),
    .error_o       (error_o),
    .configured_o  (configured_o),
    .usb_addr_o    (usb_addr_o),
    .usb_conf_o    (usb_conf_o)
  );

  always #5 clock = ~clock;

  function automatic void report_mismatch(input string msg);
    mismatches++;
    $display("mismatch at %0t ns: %s", $time, msg);
  endfunction

  function automatic void report_failure(input string msg);
    failures++;
    $display("Timeout at %0t ns: %s", $time, msg);
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic random_ready();
    rng_state = xorshift32(rng_state);
    return rng_state[0];
  endfunction

  // Payload and last hold still while the host stalls
  assert property (@(posedge clock) disable iff (reset)
      m_tvalid_o && !m_tready_i |=> m_tvalid_o && $stable(m_tdata_o) && $stable(m_tlast_o))
    else report_mismatch("stream data or last changed while stalled");

  assert property (@(posedge clock) disable iff (reset)
      m_tvalid_o && m_tready_i |-> m_tdata_o == expect_data && m_tlast_o == expect_last)
    else report_mismatch($sformatf("byte 0x%02h last %0b, expected 0x%02h last %0b",
                                   $sampled(m_tdata_o), $sampled(m_tlast_o),
                                   $sampled(expect_data), $sampled(expect_last)));

  assert property (@(posedge clock) disable iff (reset) m_tvalid_o |-> stream_open && accept_o)
    else report_mismatch("stream valid outside an accepted get request");

  assert property (@(posedge clock) disable iff (reset) !(accept_o && error_o))
    else report_mismatch("accept and error high together");

  // Setup bytes go out in USB order, one per clock
  task automatic send_setup(input logic [7:0] req_type, input logic [7:0] code,
                            input logic [15:0] value, input logic [15:0] length);
    logic [63:0] packet;
    int          i;
    packet = {length, 16'h0000, value, code, req_type};
    for (i = 0; i < 8; i++) begin
      @(negedge clock);
      setup_valid_i = 1'b1;
      setup_data_i  = packet[i*8 +: 8];
    end
    @(negedge clock);
    setup_valid_i = 1'b0;
    setup_data_i  = 8'h00;
  endtask

  task automatic wait_decision(input logic want_accept);
    int cycles;
    cycles = 0;
    transfers++;
    while (!accept_o && !error_o && cycles < 4) begin
      @(negedge clock);
      cycles++;
    end
    if (!accept_o && !error_o) begin
      report_failure("no accept or error after the setup packet");
    end else begin
      assert (accept_o == want_accept && error_o == !want_accept)
        else report_mismatch($sformatf("accept %0b error %0b, expected accept %0b",
                                       accept_o, error_o, want_accept));
    end
  endtask

  task automatic pulse_status();
    @(negedge clock);
    status_done_i = 1'b1;
    @(negedge clock);
    status_done_i = 1'b0;
  endtask

  // Decision flags drop on the edge where state is committed
  task automatic wait_idle();
    int cycles;
    cycles = 0;
    while ((accept_o || error_o) && cycles < 2) begin
      @(negedge clock);
      cycles++;
    end
    if (accept_o || error_o) begin
      report_failure("accept or error still high after the status stage");
    end
  endtask

  task automatic read_stream(input logic pressure);
    int count;
    int cycles;
    int n_bytes;
    count   = 0;
    cycles  = 0;
    n_bytes = expect_q.size();
    while (count < n_bytes && cycles < 200) begin
      @(negedge clock);
      cycles++;
      m_tready_i  = pressure ? random_ready() : 1'b1;
      expect_data = expect_q[count];
      expect_last = count == n_bytes - 1;
      assert (accept_o) else report_mismatch("accept low during the data stage");
      if (m_tvalid_o && m_tready_i) begin
        count++;
      end
    end
    if (count < n_bytes) begin
      report_failure($sformatf("stream gave %0d of %0d bytes", count, n_bytes));
    end
    @(negedge clock);
    m_tready_i = 1'b0;
    assert (!m_tvalid_o) else report_mismatch("valid still high after the last byte");
  endtask

  // Expected bytes come from the table, cut to wLength
  task automatic get_descriptor(input logic [7:0] dtype, input logic [7:0] index,
                                input logic [15:0] wlength, input int start, input int len,
                                input logic pressure);
    int n_bytes;
    int i;
    n_bytes = (len < int'(wlength)) ? len : int'(wlength);
    expect_q.delete();
    for (i = 0; i < n_bytes; i++) begin
      expect_q.push_back(usb_ctl_pkg::DESC_BYTES[start + i]);
    end
    stream_open = 1'b1;
    send_setup(8'h80, usb_ctl_pkg::REQ_GET_DESCRIPTOR, {dtype, index}, wlength);
    wait_decision(1'b1);
    read_stream(pressure);
    pulse_status();
    wait_idle();
    stream_open = 1'b0;
  endtask

  task automatic set_address(input logic [6:0] addr);
    logic [6:0] old_addr;
    old_addr = usb_addr_o;
    send_setup(8'h00, usb_ctl_pkg::REQ_SET_ADDRESS, {9'd0, addr}, 16'd0);
    wait_decision(1'b1);
    pulse_status();
    assert (usb_addr_o == old_addr) else report_mismatch("address changed before commit");
    wait_idle();
    assert (usb_addr_o == addr)
      else report_mismatch($sformatf("address 0x%02h, expected 0x%02h", usb_addr_o, addr));
  endtask

  task automatic set_configuration(input logic [7:0] value);
    send_setup(8'h00, usb_ctl_pkg::REQ_SET_CONFIGURATION, {8'h00, value}, 16'd0);
    wait_decision(1'b1);
    pulse_status();
    wait_idle();
    assert (usb_conf_o == value && configured_o == (value != 8'd0))
      else report_mismatch($sformatf("configuration %0d configured %0b after set %0d",
                                     usb_conf_o, configured_o, value));
  endtask

  task automatic reject_request(input logic [7:0] req_type, input logic [7:0] code,
                                input logic [15:0] value, input logic [15:0] length);
    logic [6:0] old_addr;
    logic [7:0] old_conf;
    logic       old_configured;
    old_addr       = usb_addr_o;
    old_conf       = usb_conf_o;
    old_configured = configured_o;
    send_setup(req_type, code, value, length);
    wait_decision(1'b0);
    @(negedge clock);
    assert (!m_tvalid_o) else report_mismatch("stream started for a rejected request");
    pulse_status();
    wait_idle();
    assert (usb_addr_o == old_addr && usb_conf_o == old_conf && configured_o == old_configured)
      else report_mismatch("rejected request changed the device state");
  endtask

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    setup_valid_i = 1'b0;
    setup_data_i  = 8'h00;
    status_done_i = 1'b0;
    m_tready_i    = 1'b0;
    mismatches    = 0;
    failures      = 0;
    transfers     = 0;
    rng_state     = 32'd6190;
    expect_data   = 8'h00;
    expect_last   = 1'b0;
    stream_open   = 1'b0;
    repeat (3) @(negedge clock);
    reset = 1'b0;
    assert (!accept_o && !error_o && !m_tvalid_o && !configured_o &&
            usb_addr_o == 7'd0 && usb_conf_o == 8'd0)
      else report_mismatch("outputs not cleared by reset");

    get_descriptor(usb_ctl_pkg::DESC_TYPE_DEVICE, 8'd0, 16'd64,
                   int'(usb_ctl_pkg::DEVICE_START), int'(usb_ctl_pkg::DEVICE_LEN), 1'b0);
    get_descriptor(usb_ctl_pkg::DESC_TYPE_CONFIG, 8'd0, 16'd9,
                   int'(usb_ctl_pkg::CONFIG_START), int'(usb_ctl_pkg::CONFIG_LEN), 1'b1);
    get_descriptor(usb_ctl_pkg::DESC_TYPE_STRING, 8'd0, 16'd255,
                   int'(usb_ctl_pkg::STRING0_START), int'(usb_ctl_pkg::STRING0_LEN), 1'b1);
    get_descriptor(usb_ctl_pkg::DESC_TYPE_STRING, 8'd2, 16'd255,
                   int'(usb_ctl_pkg::PRODUCT_START), int'(usb_ctl_pkg::PRODUCT_LEN), 1'b1);
    // String index 5 does not exist
    reject_request(8'h80, usb_ctl_pkg::REQ_GET_DESCRIPTOR,
                   {usb_ctl_pkg::DESC_TYPE_STRING, 8'd5}, 16'd255);

    set_address(7'h2A);
    set_configuration(8'd1);
    // Vendor request, then an unsupported standard bRequest
    reject_request(8'h40, usb_ctl_pkg::REQ_SET_ADDRESS, 16'h0011, 16'd0);
    reject_request(8'h00, 8'h03, 16'h0001, 16'd0);
    set_configuration(8'd0);

    repeat (2) @(negedge clock);
    $display("Summary: %0d transfers, %0d mismatches, %0d timeouts",
             transfers, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
hw/usb_ctl_pkg.sv
hw/setup_capture.sv
hw/request_decoder.sv
hw/descriptor_rom.sv
hw/desc_read_counter.sv
hw/ctl_pipe0_fsm.sv
hw/ctl_pipe0_top.sv
verification/tb_ctl_pipe0.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timing --timescale 1ns/1ns \
  -f verilog.f --top-module tb_ctl_pipe0

output="$(./obj_dir/Vtb_ctl_pipe0)"
echo "$output"

if echo "$output" | grep -qx "All tests passed"; then
  exit 0
else
  exit 1
fi
